// File: verilog/ps2Pkg.sv
`default_nettype none

package ps2Pkg;

    typedef logic [7:0] ps2Byte;                // Payload of one PS/2 frame

    typedef enum logic
    {
        modeStandard = 1'b0,                    // 3-byte packets
        modeWheel    = 1'b1                     // 4-byte packets with Z
    } mouseMode;

    // Device answers
    localparam ps2Byte ackByte    = 8'hFA;
    localparam ps2Byte idStandard = 8'h00;
    localparam ps2Byte idWheel    = 8'h03;      // Reported after the knock

    // Host commands
    localparam ps2Byte cmdSetRate = 8'hF3;
    localparam ps2Byte cmdReadId  = 8'hF2;
    localparam ps2Byte cmdEnable  = 8'hF4;      // Start streaming

endpackage

`default_nettype wire

// File: verilog/ps2Receiver.sv
`timescale 1ns/1ps
`default_nettype none

module ps2Receiver (
    input  logic           CLOCK,
    input  logic           RST_n,
    input  logic           ps2ClkIn,
    input  logic           ps2DatIn,
    input  logic           txBusy,
    output logic           devFall,
    output logic           rxValid,
    output ps2Pkg::ps2Byte rxData,
    output logic           frameError
);
    import ps2Pkg::*;

    logic [2:0] clkSync;                        // Two sync stages plus history
    logic [1:0] datSync;
    logic [3:0] bitCount;                       // 0 waits for start, 10 is stop
    ps2Byte     dataShift;
    logic       parityBit;
    logic       datBit;
    logic       frameGood;

    always_ff @(posedge CLOCK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            clkSync <= 3'b111;                  // Lines idle high
            datSync <= 2'b11;
        end
        else
        begin
            clkSync <= {clkSync[1:0], ps2ClkIn};
            datSync <= {datSync[0], ps2DatIn};
        end
    end

    assign devFall   = clkSync[2] & ~clkSync[1];
    assign datBit    = datSync[1];              // Same depth as clkSync[1]
    assign frameGood = (^{dataShift, parityBit}) & datBit;

    always_ff @(posedge CLOCK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            bitCount   <= 4'd0;
            rxValid    <= 1'b0;
            frameError <= 1'b0;
        end
        else
        begin
            rxValid    <= 1'b0;
            frameError <= 1'b0;
            if (txBusy)
                bitCount <= 4'd0;               // Host owns the lines
            else if (devFall)
            begin
                if (bitCount == 4'd0)
                begin
                    if (!datBit)
                        bitCount <= 4'd1;       // Start bit
                end
                else if (bitCount == 4'd10)
                begin
                    bitCount   <= 4'd0;
                    rxValid    <= frameGood;
                    frameError <= ~frameGood;   // Bad parity or low stop
                end
                else
                    bitCount <= bitCount + 4'd1;
            end
        end
    end

    always_ff @(posedge CLOCK)
    begin
        if (devFall && !txBusy)
        begin
            if (bitCount >= 4'd1 && bitCount <= 4'd8)
                dataShift <= {datBit, dataShift[7:1]};   // LSB first
            if (bitCount == 4'd9)
                parityBit <= datBit;
            if (bitCount == 4'd10)
                rxData <= dataShift;
        end
    end

    rxExclusive: assert property (@(posedge CLOCK) disable iff (!RST_n)
        !(rxValid && frameError));

endmodule

`default_nettype wire

// File: verilog/ps2Transmitter.sv
`timescale 1ns/1ps
`default_nettype none

module ps2Transmitter #(
    parameter logic [12:0] inhibitCycles = 13'd5000
) (
    input  logic           CLOCK,
    input  logic           RST_n,
    input  logic           devFall,
    input  logic           ps2DatIn,
    input  logic           txStart,
    input  ps2Pkg::ps2Byte txData,
    output logic           txBusy,
    output logic           txDone,
    output logic           ps2ClkLow,
    output logic           ps2DatLow
);
    localparam logic [1:0] sIdle    = 2'd0;
    localparam logic [1:0] sInhibit = 2'd1;
    localparam logic [1:0] sShift   = 2'd2;
    localparam logic [1:0] sAck     = 2'd3;

    logic [1:0]  state;
    logic [12:0] inhibitCount;
    logic [3:0]  bitIndex;                      // Data 0..7, parity 8, stop 9
    logic [9:0]  frame;

    always_ff @(posedge CLOCK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            state        <= sIdle;
            inhibitCount <= 13'd0;
            bitIndex     <= 4'd0;
            txDone       <= 1'b0;
            ps2ClkLow    <= 1'b0;
            ps2DatLow    <= 1'b0;
        end
        else
        begin
            txDone <= 1'b0;
            case (state)
                sIdle:
                    if (txStart)
                    begin
                        state        <= sInhibit;
                        inhibitCount <= 13'd0;
                        ps2ClkLow    <= 1'b1;   // Hold off the device
                    end
                sInhibit:
                    if (inhibitCount == inhibitCycles - 13'd1)
                    begin
                        ps2ClkLow <= 1'b0;
                        ps2DatLow <= 1'b1;      // Request to send, start bit
                        bitIndex  <= 4'd0;
                        state     <= sShift;
                    end
                    else
                        inhibitCount <= inhibitCount + 13'd1;
                sShift:
                    if (devFall)
                    begin
                        ps2DatLow <= ~frame[bitIndex];   // Pull low for zeros only
                        if (bitIndex == 4'd9)
                            state <= sAck;      // Stop bit releases the line
                        else
                            bitIndex <= bitIndex + 4'd1;
                    end
                default:
                    if (devFall && !ps2DatIn)
                    begin
                        state  <= sIdle;        // Device held data low
                        txDone <= 1'b1;
                    end
            endcase
        end
    end

    always_ff @(posedge CLOCK)
    begin
        if (state == sIdle && txStart)
            frame <= {1'b1, ~^txData, txData};  // Stop, odd parity, data
    end

    assign txBusy = (state != sIdle);

    startWhileIdle: assert property (@(posedge CLOCK) disable iff (!RST_n)
        txStart |-> !txBusy);

endmodule

`default_nettype wire

// File: verilog/mouseInit.sv
`timescale 1ns/1ps
`default_nettype none

module mouseInit (
    input  logic             CLOCK,
    input  logic             RST_n,
    input  logic             txBusy,
    input  logic             txDone,
    input  logic             rxValid,
    input  ps2Pkg::ps2Byte   rxData,
    output logic             txStart,
    output ps2Pkg::ps2Byte   txData,
    output logic             ready,
    output ps2Pkg::mouseMode mode
);
    import ps2Pkg::*;

    localparam logic [2:0] sSend     = 3'd0;
    localparam logic [2:0] sWaitDone = 3'd1;
    localparam logic [2:0] sWaitAck  = 3'd2;
    localparam logic [2:0] sWaitId   = 3'd3;
    localparam logic [2:0] sReady    = 3'd4;

    localparam logic [2:0] idxReadId = 3'd6;
    localparam logic [2:0] idxEnable = 3'd7;

    logic [2:0] state;
    logic [2:0] cmdIndex;
    ps2Byte     cmdByte;

    // F3 C8 F3 64 F3 50 F2 F4
    always_comb
    begin
        case (cmdIndex)
            3'd1:      cmdByte = 8'hC8;         // Rate 200
            3'd3:      cmdByte = 8'h64;         // Rate 100
            3'd5:      cmdByte = 8'h50;         // Rate 80
            idxReadId: cmdByte = cmdReadId;
            idxEnable: cmdByte = cmdEnable;
            default:   cmdByte = cmdSetRate;
        endcase
    end

    always_ff @(posedge CLOCK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            state    <= sSend;
            cmdIndex <= 3'd0;
            txStart  <= 1'b0;
            ready    <= 1'b0;
            mode     <= modeStandard;
        end
        else
        begin
            txStart <= 1'b0;
            case (state)
                sSend:
                    if (!txBusy)
                    begin
                        txStart <= 1'b1;
                        state   <= sWaitDone;
                    end
                sWaitDone:
                    if (txDone)
                        state <= sWaitAck;
                sWaitAck:
                    if (rxValid)
                    begin
                        if (rxData != ackByte)
                            state <= sSend;     // Resend the same command
                        else if (cmdIndex == idxReadId)
                            state <= sWaitId;
                        else if (cmdIndex == idxEnable)
                        begin
                            state <= sReady;
                            ready <= 1'b1;
                        end
                        else
                        begin
                            cmdIndex <= cmdIndex + 3'd1;
                            state    <= sSend;
                        end
                    end
                sWaitId:
                    if (rxValid)
                    begin
                        state <= sSend;
                        if (rxData == idWheel)
                        begin
                            mode     <= modeWheel;
                            cmdIndex <= idxEnable;
                        end
                        else if (rxData == idStandard)
                        begin
                            mode     <= modeStandard;
                            cmdIndex <= idxEnable;
                        end
                        else
                            cmdIndex <= 3'd0;   // Unknown ID, knock again
                    end
                default:
                    state <= sReady;            // Streaming
            endcase
        end
    end

    always_ff @(posedge CLOCK)
    begin
        if (state == sSend && !txBusy)
            txData <= cmdByte;
    end

endmodule

`default_nettype wire

// File: verilog/mousePacket.sv
`timescale 1ns/1ps
`default_nettype none

module mousePacket (
    input  logic              CLOCK,
    input  logic              RST_n,
    input  logic              ready,
    input  ps2Pkg::mouseMode  mode,
    input  logic              rxValid,
    input  ps2Pkg::ps2Byte    rxData,
    output logic              packetValid,
    output logic [2:0]        buttons,
    output logic signed [8:0] dx,
    output logic signed [8:0] dy,
    output logic signed [3:0] wheel
);
    import ps2Pkg::*;

    logic [1:0] byteCount;
    ps2Byte     status;                         // Buttons, signs, sync bit
    ps2Byte     dxByte;
    ps2Byte     dyByte;
    logic       take;
    logic       lastByte;

    assign take     = ready & rxValid;
    assign lastByte = (byteCount == 2'd3) ||
                      (byteCount == 2'd2 && mode == modeStandard);

    always_ff @(posedge CLOCK or negedge RST_n)
    begin
        if (!RST_n)
        begin
            byteCount   <= 2'd0;
            packetValid <= 1'b0;
        end
        else
        begin
            packetValid <= 1'b0;
            if (!ready)
                byteCount <= 2'd0;
            else if (rxValid)
            begin
                if (lastByte)
                begin
                    byteCount   <= 2'd0;
                    packetValid <= 1'b1;
                end
                else if (byteCount != 2'd0 || rxData[3])
                    byteCount <= byteCount + 2'd1;   // First byte needs bit 3
            end
        end
    end

    always_ff @(posedge CLOCK)
    begin
        if (take)
        begin
            if (byteCount == 2'd0)
                status <= rxData;
            else if (byteCount == 2'd1)
                dxByte <= rxData;
            else if (byteCount == 2'd2)
                dyByte <= rxData;

            if (lastByte)
            begin
                buttons <= status[2:0];
                dx      <= {status[4], dxByte};
                dy      <= {status[5], (byteCount == 2'd3) ? dyByte : rxData};
                wheel   <= (byteCount == 2'd3) ? rxData[3:0] : 4'd0;   // Z in low nibble
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/ps2MouseHost.sv
`timescale 1ns/1ps
`default_nettype none

module ps2MouseHost #(
    parameter logic [12:0] inhibitCycles = 13'd5000    // 100 us of CLOCK
) (
    input  logic              CLOCK,
    input  logic              RST_n,
    input  logic              ps2ClkIn,
    input  logic              ps2DatIn,
    output logic              ps2ClkLow,
    output logic              ps2DatLow,
    output logic              ready,
    output ps2Pkg::mouseMode  mode,
    output logic              packetValid,
    output logic [2:0]        buttons,
    output logic signed [8:0] dx,
    output logic signed [8:0] dy,
    output logic signed [3:0] wheel,
    output logic              frameError
);
    import ps2Pkg::*;

    logic   devFall;
    logic   txStart;
    logic   txBusy;
    logic   txDone;
    ps2Byte txData;
    logic   rxValid;
    ps2Byte rxData;

    ps2Receiver i_receiver (
        .CLOCK      (CLOCK),
        .RST_n      (RST_n),
        .ps2ClkIn   (ps2ClkIn),
        .ps2DatIn   (ps2DatIn),
        .txBusy     (txBusy),
        .devFall    (devFall),
        .rxValid    (rxValid),
        .rxData     (rxData),
        .frameError (frameError)
    );

    ps2Transmitter #(
        .inhibitCycles (inhibitCycles)
    ) i_transmitter (
        .CLOCK     (CLOCK),
        .RST_n     (RST_n),
        .devFall   (devFall),
        .ps2DatIn  (ps2DatIn),
        .txStart   (txStart),
        .txData    (txData),
        .txBusy    (txBusy),
        .txDone    (txDone),
        .ps2ClkLow (ps2ClkLow),
        .ps2DatLow (ps2DatLow)
    );

    mouseInit i_init (
        .CLOCK   (CLOCK),
        .RST_n   (RST_n),
        .txBusy  (txBusy),
        .txDone  (txDone),
        .rxValid (rxValid),
        .rxData  (rxData),
        .txStart (txStart),
        .txData  (txData),
        .ready   (ready),
        .mode    (mode)
    );

    mousePacket i_packet (
        .CLOCK       (CLOCK),
        .RST_n       (RST_n),
        .ready       (ready),
        .mode        (mode),
        .rxValid     (rxValid),
        .rxData      (rxData),
        .packetValid (packetValid),
        .buttons     (buttons),
        .dx          (dx),
        .dy          (dy),
        .wheel       (wheel)
    );

endmodule

`default_nettype wire

// File: sim/tbPs2Mouse.sv
`timescale 1ns/1ps
`default_nettype none

module tbPs2Mouse;
    import ps2Pkg::*;

    localparam logic [12:0] inhibitLen = 13'd20;
    localparam int bitHalf    = 4;              // Device clock is 8 cycles per bit
    localparam int cycleLimit = 20000;          // Two phases of about 45 frames, 130 cycles each

    logic              CLOCK;
    logic              RST_n;
    logic              devClk;                  // Device side of the open-drain lines
    logic              devDat;
    logic              ps2ClkIn;
    logic              ps2DatIn;
    logic              ps2ClkLow;
    logic              ps2DatLow;
    logic              ready;
    mouseMode          mode;
    logic              packetValid;
    logic [2:0]        buttons;
    logic signed [8:0] dx;
    logic signed [8:0] dy;
    logic signed [3:0] wheel;
    logic              frameError;

    logic        devClocking;                   // Model is toggling the clock
    logic        f4AckSent;
    logic        badFrameSent;
    logic [24:0] expQ[$];                       // buttons, dx, dy, wheel
    int          protoErrors;
    int          dataErrors;
    int          cycles;
    int          packetsSeen;
    int          frameErrSeen;
    int          frameErrExp;

    assign ps2ClkIn = devClk & ~ps2ClkLow;      // Wired-AND
    assign ps2DatIn = devDat & ~ps2DatLow;

    ps2MouseHost #(
        .inhibitCycles (inhibitLen)
    ) i_dut (
        .CLOCK       (CLOCK),
        .RST_n       (RST_n),
        .ps2ClkIn    (ps2ClkIn),
        .ps2DatIn    (ps2DatIn),
        .ps2ClkLow   (ps2ClkLow),
        .ps2DatLow   (ps2DatLow),
        .ready       (ready),
        .mode        (mode),
        .packetValid (packetValid),
        .buttons     (buttons),
        .dx          (dx),
        .dy          (dy),
        .wheel       (wheel),
        .frameError  (frameError)
    );

    initial
    begin
        CLOCK = 1'b0;
        forever #50 CLOCK = ~CLOCK;
    end

    task automatic reportAndFinish;
        $display("Protocol errors: %0d, data errors: %0d", protoErrors, dataErrors);
        if (protoErrors == 0 && dataErrors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    endtask

    always @(posedge CLOCK)
    begin
        cycles++;
        if (cycles >= cycleLimit)
        begin
            protoErrors++;
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            reportAndFinish();
        end
    end

    bothLinesFree: assert property (@(posedge CLOCK) disable iff (!RST_n)
        !(ps2ClkLow && ps2DatLow))
    else
    begin
        protoErrors++;
        $display("Host pulled clock and data low together");
    end

    clockLeftToDevice: assert property (@(posedge CLOCK) disable iff (!RST_n)
        devClocking |-> !ps2ClkLow)
    else
    begin
        protoErrors++;
        $display("Host pulled the clock low during a device clock pulse");
    end

    readyAfterEnable: assert property (@(posedge CLOCK) disable iff (!RST_n)
        $rose(ready) |-> f4AckSent)
    else
    begin
        protoErrors++;
        $display("ready rose before the enable command was acknowledged");
    end

    errorOnlyOnBadFrame: assert property (@(posedge CLOCK) disable iff (!RST_n)
        frameError |-> badFrameSent)
    else
    begin
        protoErrors++;
        $display("frameError pulsed for a good device frame");
    end

    task automatic compareValue(input string name, input logic [8:0] got,
                                input logic [8:0] exp);
        assert (got === exp)
        else
        begin
            dataErrors++;
            $display("ERR %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic checkPacket;
        logic [24:0] exp;
        packetsSeen++;
        if (expQ.size() == 0)
        begin
            dataErrors++;
            $display("Packet strobe arrived with no packet outstanding");
        end
        else
        begin
            exp = expQ.pop_front();
            compareValue("buttons", {6'd0, buttons}, {6'd0, exp[24:22]});
            compareValue("dx", dx, exp[21:13]);
            compareValue("dy", dy, exp[12:4]);
            compareValue("wheel", {5'd0, wheel}, {5'd0, exp[3:0]});
        end
    endtask

    always @(negedge CLOCK)
    begin
        if (RST_n && frameError)
            frameErrSeen++;
        if (RST_n && packetValid)
            checkPacket();
    end

    task automatic waitCycles(input int n);
        repeat (n) @(negedge CLOCK);
    endtask

    // Start, data LSB first, odd parity, stop
    task automatic sendFrame(input ps2Byte data, input logic badParity);
        logic [10:0] bits;
        int          i;
        bits = {1'b1, (~^data) ^ badParity, data, 1'b0};
        waitCycles(4);                          // Host drops txBusy first
        devClocking = 1'b1;
        for (i = 0; i < 11; i++)
        begin
            waitCycles(2);
            devDat = bits[i];
            waitCycles(2);
            devClk = 1'b0;
            waitCycles(bitHalf);
            devClk = 1'b1;
        end
        devDat      = 1'b1;
        devClocking = 1'b0;
    endtask

    task automatic readHostFrame(output ps2Byte data);
        logic [9:0] bits;
        int         held;
        int         i;
        held = 0;
        while (!ps2ClkLow)
            @(negedge CLOCK);
        while (ps2ClkLow || !ps2DatLow)
        begin
            if (ps2ClkLow)
                held++;
            @(negedge CLOCK);
        end
        assert (held >= inhibitLen)
        else
        begin
            protoErrors++;
            $display("Clock inhibit lasted only %0d cycles before request to send", held);
        end
        devClocking = 1'b1;
        waitCycles(bitHalf);
        for (i = 0; i < 10; i++)
        begin
            devClk = 1'b0;
            waitCycles(bitHalf);
            bits[i] = ps2DatIn;                 // Read just before the rising edge
            devClk  = 1'b1;
            waitCycles(bitHalf);
        end
        devDat = 1'b0;                          // Acknowledge
        waitCycles(2);
        devClk = 1'b0;
        waitCycles(bitHalf);
        devClk      = 1'b1;
        devDat      = 1'b1;
        devClocking = 1'b0;
        compareValue("hostParity", {8'd0, ^bits[8:0]}, 9'd1);   // Odd count of ones
        compareValue("hostStop", {8'd0, bits[9]}, 9'd1);
        data = bits[7:0];
    endtask

    task automatic runInit(input ps2Byte idAnswer, input int nakIndex,
                           input mouseMode expMode);
        ps2Byte cmdList [8];
        ps2Byte got;
        int     i;
        cmdList   = '{8'hF3, 8'hC8, 8'hF3, 8'h64, 8'hF3, 8'h50, 8'hF2, 8'hF4};
        f4AckSent = 1'b0;
        for (i = 0; i < 8; i++)
        begin
            readHostFrame(got);
            compareValue("hostByte", {1'b0, got}, {1'b0, cmdList[i]});
            if (i == nakIndex)
            begin
                sendFrame(8'hFE, 1'b0);         // Ask for a resend
                readHostFrame(got);
                compareValue("resentByte", {1'b0, got}, {1'b0, cmdList[i]});
            end
            if (i == 7)
            begin
                compareValue("ready", {8'd0, ready}, 9'd0);
                f4AckSent = 1'b1;
            end
            sendFrame(ackByte, 1'b0);
            if (i == 6)
                sendFrame(idAnswer, 1'b0);
        end
        while (!ready)
            @(negedge CLOCK);
        compareValue("mode", {8'd0, mode}, {8'd0, expMode});
    endtask

    task automatic sendPacket(input mouseMode pktMode);
        ps2Byte     status;
        ps2Byte     xByte;
        ps2Byte     yByte;
        logic [3:0] zNib;
        status = ps2Byte'($urandom) | 8'h08;    // Sync bit set
        xByte  = ps2Byte'($urandom);
        yByte  = ps2Byte'($urandom);
        zNib   = 4'($urandom);
        expQ.push_back({status[2:0], status[4], xByte, status[5], yByte,
                        (pktMode == modeWheel) ? zNib : 4'h0});
        sendFrame(status, 1'b0);
        sendFrame(xByte, 1'b0);
        sendFrame(yByte, 1'b0);
        if (pktMode == modeWheel)
            sendFrame({{4{zNib[3]}}, zNib}, 1'b0);
        while (expQ.size() != 0)
            @(negedge CLOCK);
    endtask

    task automatic sendBadParity;
        badFrameSent = 1'b1;
        frameErrExp++;
        sendFrame(ps2Byte'($urandom) | 8'h08, 1'b1);
        waitCycles(2);
        badFrameSent = 1'b0;
        compareValue("frameErrorCount", 9'(frameErrSeen), 9'(frameErrExp));
    endtask

    task automatic runStream(input mouseMode pktMode);
        repeat (5) sendPacket(pktMode);
        sendFrame(ps2Byte'($urandom) & 8'hF7, 1'b0);   // Stray byte, no sync bit
        sendPacket(pktMode);
        sendBadParity();
        sendPacket(pktMode);
    endtask

    task automatic applyReset;
        RST_n = 1'b0;
        waitCycles(3);
        RST_n = 1'b1;
    endtask

    initial
    begin
        void'($urandom(59941));
        RST_n        = 1'b0;
        devClk       = 1'b1;
        devDat       = 1'b1;
        devClocking  = 1'b0;
        f4AckSent    = 1'b0;
        badFrameSent = 1'b0;
        protoErrors  = 0;
        dataErrors   = 0;
        cycles       = 0;
        packetsSeen  = 0;
        frameErrSeen = 0;
        frameErrExp  = 0;
        applyReset();
        runInit(idWheel, 3, modeWheel);
        runStream(modeWheel);
        applyReset();                           // Phase two, standard mouse
        runInit(idStandard, 6, modeStandard);
        runStream(modeStandard);
        waitCycles(10);
        compareValue("packetCount", 9'(packetsSeen), 9'd14);
        reportAndFinish();
    end

endmodule

`default_nettype wire

// File: compile.f
verilog/ps2Pkg.sv
verilog/ps2Receiver.sv
verilog/ps2Transmitter.sv
verilog/mouseInit.sv
verilog/mousePacket.sv
verilog/ps2MouseHost.sv
sim/tbPs2Mouse.sv

// File: run.sh
#!/bin/sh
# Build and run the PS/2 mouse host testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module tbPs2Mouse -Mdir obj_dir -o simTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
